//--- verif/dcache_testdata.txt
// Columns: group op func addr data fill_state fill_line check_mask
// then expected: hit load_data victim_valid victim_dirty victim_addr victim_line
// op 0 load, 1 store, 2 fill, f end; mask bit 0 hit, 1 data, 2 victim valid, 3 victim rest
1 0 2 00000000 0 0 0 5 0 0 0 0 0 0
1 0 3 abcdeff0 0 0 0 5 0 0 0 0 0 0
2 2 2 00000100 0 2 8899aabbfedc80701234567880f07f01 4 0 0 0 0 0 0
2 0 2 00000100 0 0 0 7 1 80f07f01 0 0 0 0
2 0 2 0000010c 0 0 0 7 1 8899aabb 0 0 0 0
2 0 1 00000102 0 0 0 7 1 ffff80f0 0 0 0 0
2 0 4 00000102 0 0 0 7 1 000080f0 0 0 0 0
2 0 0 00000103 0 0 0 7 1 ffffff80 0 0 0 0
2 0 3 00000102 0 0 0 7 1 000000f0 0 0 0 0
2 0 0 00000101 0 0 0 7 1 0000007f 0 0 0 0
2 0 1 00000100 0 0 0 7 1 00007f01 0 0 0 0
3 1 5 00000105 000000aa 0 0 5 1 0 0 0 0 0
3 0 2 00000104 0 0 0 7 1 1234aa78 0 0 0 0
3 1 6 0000010e 0000cafe 0 0 5 1 0 0 0 0 0
3 1 7 00000108 deadbeef 0 0 5 1 0 0 0 0 0
3 0 2 0000010c 0 0 0 7 1 cafeaabb 0 0 0 0
3 0 2 00000108 0 0 0 7 1 deadbeef 0 0 0 0
3 1 5 00000100 00000055 0 0 5 1 0 0 0 0 0
3 0 2 00000030 0 0 0 5 0 0 0 0 0 0
3 0 2 00000100 0 0 0 7 1 80f07f55 0 0 0 0
4 2 2 00002020 0 2 44444444333333332222222211111111 4 0 0 0 0 0 0
4 0 2 00002024 0 0 0 7 1 22222222 0 0 0 0
4 1 7 00002028 0badf00d 0 0 5 1 0 0 0 0 0
4 0 2 00002028 0 0 0 7 1 0badf00d 0 0 0 0
4 1 6 00002020 0000beef 0 0 5 1 0 0 0 0 0
4 1 6 00002022 0000f00d 0 0 5 1 0 0 0 0 0
4 0 2 00002020 0 0 0 7 1 f00dbeef 0 0 0 0
5 2 2 00000300 0 2 d3d3d3d3c3c3c3c3b3b3b3b3a3a3a3a3 c 0 0 1 1 00000100 cafeaabbdeadbeef1234aa7880f07f55
5 0 2 0000030c 0 0 0 7 1 d3d3d3d3 0 0 0 0
5 0 2 00000100 0 0 0 5 0 0 0 0 0 0
5 2 2 000000f0 0 2 0f0f0f0f0e0e0e0e0d0d0d0d0c0c0c0c 4 0 0 0 0 0 0
5 0 3 000000f4 0 0 0 7 1 0000000d 0 0 0 0
5 2 2 000055f0 0 2 ffffffffeeeeeeeeddddddddcccccccc c 0 0 1 0 000000f0 0f0f0f0f0e0e0e0e0d0d0d0d0c0c0c0c
5 2 2 000066f0 0 2 66666666777777778888888899999999 c 0 0 1 0 000055f0 ffffffffeeeeeeeeddddddddcccccccc
6 1 7 00003028 12121212 0 0 5 0 0 0 0 0 0
6 0 2 00003028 0 0 0 5 0 0 0 0 0 0
6 0 2 00002028 0 0 0 7 1 0badf00d 0 0 0 0
6 1 5 00000050 00000077 0 0 5 0 0 0 0 0 0
6 0 3 00000050 0 0 0 5 0 0 0 0 0 0
0 f 0 0 0 0 0 0 0 0 0 0 0 0

//--- dcache.f
source/dcache_pkg.sv
source/dcache_d0.sv
source/dcache_d1.sv
source/dcache_array.sv
source/dcache.sv
verif/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/dcache_d0.sv
  - source/dcache_d1.sv
  - source/dcache_array.sv
  - source/dcache.sv
  - target: test
    files:
      - verif/dcache_tb.sv

//--- verif/dcache_tb.sv
`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int unsigned CACHE_SIZE    = 256;
    localparam int unsigned LINE_SIZE     = 16;
    localparam int unsigned LINE_WIDTH    = LINE_SIZE * 8;
    localparam int unsigned FIELDS        = 14;
    localparam int unsigned MAX_REQS      = 64;
    localparam int unsigned RESET_TIMEOUT = 16;

    // Column positions within one request of the data file
    localparam int COL_GRP    = 0;
    localparam int COL_OP     = 1;
    localparam int COL_FUNC   = 2;
    localparam int COL_ADDR   = 3;
    localparam int COL_DATA   = 4;
    localparam int COL_FSTATE = 5;
    localparam int COL_FLINE  = 6;
    localparam int COL_MASK   = 7;
    localparam int COL_HIT    = 8;
    localparam int COL_RDATA  = 9;
    localparam int COL_VVALID = 10;
    localparam int COL_VDIRTY = 11;
    localparam int COL_VADDR  = 12;
    localparam int COL_VLINE  = 13;

    typedef struct packed {
        logic [3:0]            mask;
        logic                  hit;
        data_t                 data;
        logic                  victim_valid;
        logic                  victim_dirty;
        addr_t                 victim_addr;
        logic [LINE_WIDTH-1:0] victim_line;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  i_rst;
    logic                  i_dc_wr_en;
    logic                  i_dc_fill;
    addr_t                 i_dc_addr;
    lsu_func_t             i_dc_func;
    data_t                 i_dc_data;
    line_state_t           i_dc_fill_state;
    logic [LINE_WIDTH-1:0] i_dc_fill_data;
    logic                  o_dc_hit;
    data_t                 o_dc_data;
    logic                  o_dc_victim_valid;
    logic                  o_dc_victim_dirty;
    addr_t                 o_dc_victim_addr;
    logic [LINE_WIDTH-1:0] o_dc_victim_data;

    logic [127:0] vec_mem [MAX_REQS*FIELDS];
    expect_t      exp_q [MAX_REQS];
    int           grp_q [MAX_REQS];
    int           num_reqs;
    int           errors;
    int           checks;
    int           cur_grp;
    int           grp_reqs;
    int           grp_err_base;

    always #2 clk = ~clk;

    dcache #(
        .OPTN_DC_CACHE_SIZE(CACHE_SIZE),
        .OPTN_DC_LINE_SIZE(LINE_SIZE)
    ) uut (
        .clk(clk),
        .i_rst(i_rst),
        .i_dc_wr_en(i_dc_wr_en),
        .i_dc_fill(i_dc_fill),
        .i_dc_addr(i_dc_addr),
        .i_dc_func(i_dc_func),
        .i_dc_data(i_dc_data),
        .i_dc_fill_state(i_dc_fill_state),
        .i_dc_fill_data(i_dc_fill_data),
        .o_dc_hit(o_dc_hit),
        .o_dc_data(o_dc_data),
        .o_dc_victim_valid(o_dc_victim_valid),
        .o_dc_victim_dirty(o_dc_victim_dirty),
        .o_dc_victim_addr(o_dc_victim_addr),
        .o_dc_victim_data(o_dc_victim_data)
    );

    function automatic logic [127:0] fetch_field(int req, int col);
        return vec_mem[req * FIELDS + col];
    endfunction

    task automatic drive_idle();
        i_dc_wr_en      = 1'b0;
        i_dc_fill       = 1'b0;
        i_dc_addr       = '0;
        i_dc_func       = LSU_LW;
        i_dc_data       = '0;
        i_dc_fill_state = '0;
        i_dc_fill_data  = '0;
    endtask

    task automatic drive_request(int idx);
        logic [127:0] op;
        if (idx >= num_reqs) begin
            drive_idle();
        end else begin
            op              = fetch_field(idx, COL_OP);
            i_dc_wr_en      = (op == 1);
            i_dc_fill       = (op == 2);
            i_dc_addr       = fetch_field(idx, COL_ADDR);
            i_dc_func       = lsu_func_t'(fetch_field(idx, COL_FUNC) & 3'b111);
            i_dc_data       = fetch_field(idx, COL_DATA);
            i_dc_fill_state = line_state_t'(fetch_field(idx, COL_FSTATE) & 2'b11);
            i_dc_fill_data  = fetch_field(idx, COL_FLINE);
        end
    endtask

    task automatic check_value(string name, logic [127:0] exp_val, logic [127:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic close_group();
        if (cur_grp >= 0) begin
            $display("group %0d done: %0d requests, %0d errors",
                     cur_grp, grp_reqs, errors - grp_err_base);
        end
    endtask

    task automatic check_result(int idx);
        expect_t e;
        e = exp_q[idx];
        if (grp_q[idx] != cur_grp) begin
            close_group();
            cur_grp      = grp_q[idx];
            grp_reqs     = 0;
            grp_err_base = errors;
        end
        grp_reqs++;
        if (e.mask[0]) check_value("o_dc_hit", e.hit, o_dc_hit);
        if (e.mask[1]) check_value("o_dc_data", e.data, o_dc_data);
        if (e.mask[2]) check_value("o_dc_victim_valid", e.victim_valid, o_dc_victim_valid);
        if (e.mask[3]) begin
            check_value("o_dc_victim_dirty", e.victim_dirty, o_dc_victim_dirty);
            check_value("o_dc_victim_addr", e.victim_addr, o_dc_victim_addr);
            check_value("o_dc_victim_data", e.victim_line, o_dc_victim_data);
        end
    endtask

    initial begin
        int   wait_cycles;
        logic aborted;

        aborted  = 1'b0;
        errors   = 0;
        checks   = 0;
        cur_grp  = -1;
        grp_reqs = 0;
        i_rst    = 1'b1;
        drive_idle();

        $readmemh("verif/dcache_testdata.txt", vec_mem);

        // An op code of f ends the request list
        num_reqs = 0;
        while (num_reqs < MAX_REQS && fetch_field(num_reqs, COL_OP) !== 128'hf) begin
            num_reqs++;
        end
        if (num_reqs >= MAX_REQS) begin
            $display("No end marker found in the test data within %0d requests", MAX_REQS);
            aborted = 1'b1;
        end else if (num_reqs == 0) begin
            $display("The test data holds no requests");
            aborted = 1'b1;
        end

        for (int n = 0; n < num_reqs; n++) begin
            grp_q[n]              = fetch_field(n, COL_GRP);
            exp_q[n].mask         = fetch_field(n, COL_MASK);
            exp_q[n].hit          = fetch_field(n, COL_HIT);
            exp_q[n].data         = fetch_field(n, COL_RDATA);
            exp_q[n].victim_valid = fetch_field(n, COL_VVALID);
            exp_q[n].victim_dirty = fetch_field(n, COL_VDIRTY);
            exp_q[n].victim_addr  = fetch_field(n, COL_VADDR);
            exp_q[n].victim_line  = fetch_field(n, COL_VLINE);
        end

        if (!aborted) begin
            repeat (3) @(posedge clk);
            #1;
            i_rst = 1'b0;
            wait_cycles = 0;
            while ((o_dc_hit !== 1'b0 || o_dc_victim_valid !== 1'b0) &&
                   wait_cycles < RESET_TIMEOUT) begin
                @(posedge clk);
                #1;
                wait_cycles++;
            end
            if (o_dc_hit !== 1'b0 || o_dc_victim_valid !== 1'b0) begin
                $display("Outputs did not clear within %0d cycles of reset", RESET_TIMEOUT);
                aborted = 1'b1;
            end
        end

        // Results of a request are registered two edges after it is driven
        if (!aborted) begin
            for (int cyc = 0; cyc < num_reqs + 2; cyc++) begin
                if (cyc >= 2) begin
                    check_result(cyc - 2);
                end
                drive_request(cyc);
                @(posedge clk);
                #1;
            end
            close_group();
        end

        $display("%0d requests, %0d checks, %0d errors", num_reqs, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/dcache.sv
`default_nettype none

module dcache #(
    parameter int unsigned OPTN_DC_CACHE_SIZE = 1024,
    parameter int unsigned OPTN_DC_LINE_SIZE  = 32,

    localparam int unsigned LINE_WIDTH = OPTN_DC_LINE_SIZE * 8
)(
    input  wire                     clk,
    input  wire                     i_rst,

    input  wire                     i_dc_wr_en,
    input  wire                     i_dc_fill,
    input  dcache_pkg::addr_t       i_dc_addr,
    input  dcache_pkg::lsu_func_t   i_dc_func,
    input  dcache_pkg::data_t       i_dc_data,
    input  dcache_pkg::line_state_t i_dc_fill_state,
    input  wire  [LINE_WIDTH-1:0]   i_dc_fill_data,

    output logic                    o_dc_hit,
    output dcache_pkg::data_t       o_dc_data,
    output logic                    o_dc_victim_valid,
    output logic                    o_dc_victim_dirty,
    output dcache_pkg::addr_t       o_dc_victim_addr,
    output logic [LINE_WIDTH-1:0]   o_dc_victim_data
);

    import dcache_pkg::*;

    localparam int unsigned OFFSET_WIDTH = $clog2(OPTN_DC_LINE_SIZE);
    localparam int unsigned INDEX_WIDTH  = $clog2(OPTN_DC_CACHE_SIZE / OPTN_DC_LINE_SIZE);
    localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    logic [INDEX_WIDTH-1:0] rd_index;
    dc_stage_t              stage_q;
    logic [LINE_WIDTH-1:0]  fill_line_q;
    line_state_t            rd_state;
    logic [TAG_WIDTH-1:0]   rd_tag;
    logic [LINE_WIDTH-1:0]  rd_line;
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    line_state_t            wr_state;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [LINE_WIDTH-1:0]  wr_line;

    // The array read starts in the same cycle the request is registered
    assign rd_index = i_dc_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    dcache_d0 #(
        .OPTN_DC_LINE_SIZE(OPTN_DC_LINE_SIZE)
    ) dcache_d0_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_wr_en(i_dc_wr_en),
        .i_fill(i_dc_fill),
        .i_addr(i_dc_addr),
        .i_func(i_dc_func),
        .i_data(i_dc_data),
        .i_fill_state(i_dc_fill_state),
        .i_fill_data(i_dc_fill_data),
        .o_stage(stage_q),
        .o_fill_data(fill_line_q)
    );

    dcache_d1 #(
        .OPTN_DC_CACHE_SIZE(OPTN_DC_CACHE_SIZE),
        .OPTN_DC_LINE_SIZE(OPTN_DC_LINE_SIZE)
    ) dcache_d1_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_stage(stage_q),
        .i_fill_data(fill_line_q),
        .i_rd_state(rd_state),
        .i_rd_tag(rd_tag),
        .i_rd_line(rd_line),
        .o_wr_en(wr_en),
        .o_wr_index(wr_index),
        .o_wr_state(wr_state),
        .o_wr_tag(wr_tag),
        .o_wr_line(wr_line),
        .o_hit(o_dc_hit),
        .o_data(o_dc_data),
        .o_victim_valid(o_dc_victim_valid),
        .o_victim_dirty(o_dc_victim_dirty),
        .o_victim_addr(o_dc_victim_addr),
        .o_victim_data(o_dc_victim_data)
    );

    dcache_array #(
        .OPTN_DC_CACHE_SIZE(OPTN_DC_CACHE_SIZE),
        .OPTN_DC_LINE_SIZE(OPTN_DC_LINE_SIZE)
    ) dcache_array_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_wr_en(wr_en),
        .i_wr_index(wr_index),
        .i_wr_state(wr_state),
        .i_wr_tag(wr_tag),
        .i_wr_line(wr_line),
        .i_rd_index(rd_index),
        .o_rd_state(rd_state),
        .o_rd_tag(rd_tag),
        .o_rd_line(rd_line)
    );

endmodule

`default_nettype wire

//--- source/dcache_array.sv
`default_nettype none

module dcache_array #(
    parameter int unsigned OPTN_DC_CACHE_SIZE = 1024,
    parameter int unsigned OPTN_DC_LINE_SIZE  = 32,

    localparam int unsigned LINE_WIDTH   = OPTN_DC_LINE_SIZE * 8,
    localparam int unsigned NUM_LINES    = OPTN_DC_CACHE_SIZE / OPTN_DC_LINE_SIZE,
    localparam int unsigned OFFSET_WIDTH = $clog2(OPTN_DC_LINE_SIZE),
    localparam int unsigned INDEX_WIDTH  = $clog2(NUM_LINES),
    localparam int unsigned TAG_WIDTH    = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
)(
    input  wire                     clk,
    input  wire                     i_rst,

    input  wire                     i_wr_en,
    input  wire  [INDEX_WIDTH-1:0]  i_wr_index,
    input  dcache_pkg::line_state_t i_wr_state,
    input  wire  [TAG_WIDTH-1:0]    i_wr_tag,
    input  wire  [LINE_WIDTH-1:0]   i_wr_line,

    input  wire  [INDEX_WIDTH-1:0]  i_rd_index,
    output dcache_pkg::line_state_t o_rd_state,
    output logic [TAG_WIDTH-1:0]    o_rd_tag,
    output logic [LINE_WIDTH-1:0]   o_rd_line
);

    import dcache_pkg::*;

    line_state_t           state_mem [NUM_LINES];
    logic [TAG_WIDTH-1:0]  tag_mem   [NUM_LINES];
    logic [LINE_WIDTH-1:0] line_mem  [NUM_LINES];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
        o_rd_tag  <= tag_mem[i_rd_index];
        o_rd_line <= line_mem[i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_mem[i] <= '0;
            end
            o_rd_state <= '0;
        end else begin
            if (i_wr_en) begin
                state_mem[i_wr_index] <= i_wr_state;
            end
            o_rd_state <= state_mem[i_rd_index];
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_d1.sv
`default_nettype none

module dcache_d1 #(
    parameter int unsigned OPTN_DC_CACHE_SIZE = 1024,
    parameter int unsigned OPTN_DC_LINE_SIZE  = 32,

    localparam int unsigned LINE_WIDTH   = OPTN_DC_LINE_SIZE * 8,
    localparam int unsigned OFFSET_WIDTH = $clog2(OPTN_DC_LINE_SIZE),
    localparam int unsigned INDEX_WIDTH  = $clog2(OPTN_DC_CACHE_SIZE / OPTN_DC_LINE_SIZE),
    localparam int unsigned TAG_WIDTH    = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
)(
    input  wire                     clk,
    input  wire                     i_rst,

    input  dcache_pkg::dc_stage_t   i_stage,
    input  wire  [LINE_WIDTH-1:0]   i_fill_data,
    input  dcache_pkg::line_state_t i_rd_state,
    input  wire  [TAG_WIDTH-1:0]    i_rd_tag,
    input  wire  [LINE_WIDTH-1:0]   i_rd_line,

    output logic                    o_wr_en,
    output logic [INDEX_WIDTH-1:0]  o_wr_index,
    output dcache_pkg::line_state_t o_wr_state,
    output logic [TAG_WIDTH-1:0]    o_wr_tag,
    output logic [LINE_WIDTH-1:0]   o_wr_line,

    output logic                    o_hit,
    output dcache_pkg::data_t       o_data,
    output logic                    o_victim_valid,
    output logic                    o_victim_dirty,
    output dcache_pkg::addr_t       o_victim_addr,
    output logic [LINE_WIDTH-1:0]   o_victim_data
);

    import dcache_pkg::*;

    logic [TAG_WIDTH-1:0]        tag;
    logic [INDEX_WIDTH-1:0]      index;
    logic [OFFSET_WIDTH-3:0]     word_sel;
    logic [1:0]                  byte_off;
    logic                        fwd_valid_q;
    logic [INDEX_WIDTH-1:0]      fwd_index_q;
    line_state_t                 fwd_state_q;
    logic [TAG_WIDTH-1:0]        fwd_tag_q;
    logic [LINE_WIDTH-1:0]       fwd_line_q;
    logic                        use_fwd;
    line_state_t                 cur_state;
    logic [TAG_WIDTH-1:0]        cur_tag;
    logic [LINE_WIDTH-1:0]       cur_line;
    logic                        hit;
    data_t                       word;
    logic [7:0]                  byte_val;
    logic [15:0]                 half_val;
    data_t                       load_data;
    logic [LINE_WIDTH-1:0]       merged_line;

    assign tag      = i_stage.addr[OFFSET_WIDTH+INDEX_WIDTH +: TAG_WIDTH];
    assign index    = i_stage.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign word_sel = i_stage.addr[OFFSET_WIDTH-1:2];
    assign byte_off = i_stage.addr[1:0];

    // The array read for this index left before the previous write landed
    assign use_fwd   = fwd_valid_q && (fwd_index_q == index);
    assign cur_state = use_fwd ? fwd_state_q : i_rd_state;
    assign cur_tag   = use_fwd ? fwd_tag_q : i_rd_tag;
    assign cur_line  = use_fwd ? fwd_line_q : i_rd_line;

    assign hit = cur_state.valid && (cur_tag == tag);

    assign word     = cur_line[word_sel*DATA_WIDTH +: DATA_WIDTH];
    assign byte_val = word[byte_off*8 +: 8];
    assign half_val = word[byte_off[1]*16 +: 16];

    always_comb begin
        case (i_stage.func)
            LSU_LB:  load_data = {{24{byte_val[7]}}, byte_val};
            LSU_LH:  load_data = {{16{half_val[15]}}, half_val};
            LSU_LBU: load_data = {24'b0, byte_val};
            LSU_LHU: load_data = {16'b0, half_val};
            default: load_data = word;
        endcase
    end

    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < DATA_WIDTH / 8; b++) begin
            if (i_stage.byte_sel[b]) begin
                merged_line[word_sel*DATA_WIDTH + b*8 +: 8] = i_stage.data[b*8 +: 8];
            end
        end
    end

    // Store hits and fills are committed at the closing edge of this stage
    assign o_wr_en          = i_stage.fill || (i_stage.wr_en && hit);
    assign o_wr_index       = index;
    assign o_wr_tag         = tag;
    assign o_wr_state.valid = i_stage.fill ? i_stage.state.valid : 1'b1;
    assign o_wr_state.dirty = i_stage.fill ? i_stage.state.dirty : 1'b1;
    assign o_wr_line        = i_stage.fill ? i_fill_data : merged_line;

    always_ff @(posedge clk) begin
        if (o_wr_en) begin
            fwd_index_q <= o_wr_index;
            fwd_state_q <= o_wr_state;
            fwd_tag_q   <= o_wr_tag;
            fwd_line_q  <= o_wr_line;
        end
        if (i_rst) begin
            fwd_valid_q <= 1'b0;
        end else if (o_wr_en) begin
            fwd_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        o_hit          <= hit;
        o_data         <= load_data;
        o_victim_valid <= i_stage.fill && cur_state.valid;
        o_victim_dirty <= cur_state.dirty;
        o_victim_addr  <= {cur_tag, index, {OFFSET_WIDTH{1'b0}}};
        o_victim_data  <= cur_line;
        if (i_rst) begin
            o_hit          <= 1'b0;
            o_victim_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_d0.sv
`default_nettype none

module dcache_d0 #(
    parameter int unsigned OPTN_DC_LINE_SIZE = 32,

    localparam int unsigned LINE_WIDTH = OPTN_DC_LINE_SIZE * 8
)(
    input  wire                     clk,
    input  wire                     i_rst,

    input  wire                     i_wr_en,
    input  wire                     i_fill,
    input  dcache_pkg::addr_t       i_addr,
    input  dcache_pkg::lsu_func_t   i_func,
    input  dcache_pkg::data_t       i_data,
    input  dcache_pkg::line_state_t i_fill_state,
    input  wire  [LINE_WIDTH-1:0]   i_fill_data,

    output dcache_pkg::dc_stage_t   o_stage,
    output logic [LINE_WIDTH-1:0]   o_fill_data
);

    import dcache_pkg::*;

    byte_sel_t             sel_base;
    dc_stage_t             stage_d;
    dc_stage_t             stage_q;
    logic [LINE_WIDTH-1:0] fill_data_q;

    // Byte enables before they are moved to the addressed byte lane
    always_comb begin
        case (i_func)
            LSU_SB:  sel_base = 4'b0001;
            LSU_SH:  sel_base = 4'b0011;
            LSU_SW:  sel_base = 4'b1111;
            default: sel_base = 4'b0000;
        endcase
    end

    always_comb begin
        stage_d.wr_en    = i_wr_en;
        stage_d.fill     = i_fill;
        stage_d.addr     = i_addr;
        stage_d.func     = i_func;
        stage_d.state    = i_fill_state;
        stage_d.byte_sel = sel_base << i_addr[1:0];
        // Store data lands on the same lanes as its enables
        stage_d.data     = i_data << {i_addr[1:0], 3'b000};
    end

    always_ff @(posedge clk) begin
        stage_q     <= stage_d;
        fill_data_q <= i_fill_data;
        if (i_rst) begin
            stage_q.wr_en <= 1'b0;
            stage_q.fill  <= 1'b0;
        end
    end

    assign o_stage     = stage_q;
    assign o_fill_data = fill_data_q;

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned ADDR_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH/8-1:0] byte_sel_t;

    // Loads come first, stores take the top three codes
    typedef enum logic [2:0] {
        LSU_LB  = 3'b000,
        LSU_LH  = 3'b001,
        LSU_LW  = 3'b010,
        LSU_LBU = 3'b011,
        LSU_LHU = 3'b100,
        LSU_SB  = 3'b101,
        LSU_SH  = 3'b110,
        LSU_SW  = 3'b111
    } lsu_func_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } line_state_t;

    // Request as it leaves stage 0; data is already shifted to its byte lanes
    typedef struct packed {
        logic        wr_en;
        logic        fill;
        addr_t       addr;
        lsu_func_t   func;
        byte_sel_t   byte_sel;
        data_t       data;
        line_state_t state;
    } dc_stage_t;

endpackage

`default_nettype wire
